//--- aether_pkg.sv
package aether_pkg;

  // ------------------------------
  // Memory port
  // ------------------------------
  localparam int MemAddrWidth = 24;
  localparam int MemDataWidth = 16;

  typedef struct packed {
    logic                    valid;
    logic [MemAddrWidth-1:0] addr;  // Word address
  } mem_req_t;

  typedef struct packed {
    logic                    valid;
    logic [MemDataWidth-1:0] data;
  } mem_rsp_t;

  // ------------------------------
  // Host instruction set
  // ------------------------------
  typedef enum logic [3:0] {
    NOP = 4'h0,
    RST = 4'h1,  // param_1 picks the reset target
    RDR = 4'h2,
    WRR = 4'h3,
    LDW = 4'h4,
    CNV = 4'h5
  } opcode_e;

  typedef enum logic [3:0] {
    VERSN = 4'h0,
    HWRID = 4'h1,
    MEMUP = 4'h2,  // Upper address byte
    MSTRT = 4'h3,  // Kernel base
    MENDD = 4'h4,  // Activation base
    BCFG1 = 4'h5,  // Matrix width
    STATS = 4'h9
  } reg_idx_e;

  typedef enum logic [3:0] {
    CWGT = 4'h0,
    CONV = 4'h1,
    REGS = 4'h4,
    FULL = 4'h5   // Everything above at once
  } rst_sel_e;

  // Register values out of reset
  localparam logic [15:0] VersnValue = 16'h6C00;
  localparam logic [15:0] HwridValue = 16'hB2E9;
  localparam logic [15:0] MemupReset = 16'h0000;
  localparam logic [15:0] MstrtReset = 16'h0000;
  localparam logic [15:0] MenddReset = 16'h0000;
  localparam logic [15:0] Bcfg1Reset = 16'h0001;

endpackage

//--- aether_decoder.sv
`timescale 1ns/10ps

module aether_decoder
  import aether_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  opcode_e                 instruction_i,
  input  logic [3:0]              param_1_i,
  input  logic [15:0]             param_2_i,
  input  logic                    wgt_busy_i,
  input  logic                    conv_busy_i,
  input  logic                    conv_done_i,
  output logic [15:0]             data_o,
  output logic                    wgt_start_o,
  output logic                    conv_start_o,
  output logic [MemAddrWidth-1:0] wgt_base_o,
  output logic [MemAddrWidth-1:0] act_base_o,
  output logic [15:0]             width_o,
  output logic                    rst_conv_o,
  output logic                    rst_cwgt_o,
  output logic                    interrupt_o
);

  logic [15:0] memup_q;
  logic [15:0] mstrt_q;
  logic [15:0] mendd_q;
  logic [15:0] bcfg1_q;
  logic        done_q;   // Sticky convolution done

  reg_idx_e    reg_idx;
  rst_sel_e    rst_sel;
  logic        sel_conv;
  logic        sel_cwgt;
  logic        sel_regs;
  logic [15:0] stats;
  logic [15:0] rd_data;

  assign reg_idx = reg_idx_e'(param_1_i);
  assign rst_sel = rst_sel_e'(param_1_i);

  // Reset targets, FULL hits all of them
  assign sel_conv = (instruction_i == RST) && (rst_sel == CONV || rst_sel == FULL);
  assign sel_cwgt = (instruction_i == RST) && (rst_sel == CWGT || rst_sel == FULL);
  assign sel_regs = (instruction_i == RST) && (rst_sel == REGS || rst_sel == FULL);

  assign stats      = {13'd0, done_q, conv_busy_i, wgt_busy_i};
  assign wgt_base_o = {memup_q[7:0], mstrt_q};
  assign act_base_o = {memup_q[7:0], mendd_q};
  assign width_o    = bcfg1_q;

  // ------------------------------
  // Register file
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      memup_q <= MemupReset;
      mstrt_q <= MstrtReset;
      mendd_q <= MenddReset;
      bcfg1_q <= Bcfg1Reset;
    end
    else if (sel_regs)
    begin
      memup_q <= MemupReset;
      mstrt_q <= MstrtReset;
      mendd_q <= MenddReset;
      bcfg1_q <= Bcfg1Reset;
    end
    else if (instruction_i == WRR)
    begin
      case (reg_idx)
        MEMUP:   memup_q <= param_2_i;
        MSTRT:   mstrt_q <= param_2_i;
        MENDD:   mendd_q <= param_2_i;
        BCFG1:   bcfg1_q <= param_2_i;
        default: ;  // Read-only or unmapped
      endcase
    end
  end

  always_comb
  begin
    case (reg_idx)
      VERSN:   rd_data = VersnValue;
      HWRID:   rd_data = HwridValue;
      MEMUP:   rd_data = memup_q;
      MSTRT:   rd_data = mstrt_q;
      MENDD:   rd_data = mendd_q;
      BCFG1:   rd_data = bcfg1_q;
      STATS:   rd_data = stats;
      default: rd_data = 16'h0000;
    endcase
  end

  // ------------------------------
  // Pulses and read port
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      data_o       <= 16'h0000;
      wgt_start_o  <= 1'b0;
      conv_start_o <= 1'b0;
      rst_conv_o   <= 1'b0;
      rst_cwgt_o   <= 1'b0;
      interrupt_o  <= 1'b0;
      done_q       <= 1'b0;
    end
    else
    begin
      if (instruction_i == RDR)
        data_o <= rd_data;  // Held until the next read
      wgt_start_o  <= (instruction_i == LDW);
      conv_start_o <= (instruction_i == CNV);
      rst_conv_o   <= sel_conv;
      rst_cwgt_o   <= sel_cwgt;
      interrupt_o  <= conv_done_i;
      if (sel_conv || instruction_i == CNV)
        done_q <= 1'b0;
      else if (conv_done_i)
        done_q <= 1'b1;
    end
  end

  // A selected reset leaves its fetcher idle, whatever start follows
  a_rst_idles_fetcher: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rst_cwgt_o |=> !wgt_busy_i) and (rst_conv_o |=> !conv_busy_i));

endmodule

//--- mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter
  import aether_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t wgt_req_i,
  output mem_rsp_t wgt_rsp_o,
  input  mem_req_t conv_req_i,
  output mem_rsp_t conv_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  logic busy_q;        // Read in flight
  logic owner_conv_q;  // Which fetcher owns it
  logic grant_conv;

  // Weights win ties, grant frozen while a read is out
  assign grant_conv = busy_q ? owner_conv_q : !wgt_req_i.valid;
  assign mem_req_o  = grant_conv ? conv_req_i : wgt_req_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q       <= 1'b0;
      owner_conv_q <= 1'b0;
    end
    else if (busy_q)
    begin
      if (mem_rsp_i.valid)
        busy_q <= 1'b0;
    end
    else if (mem_req_o.valid)
    begin
      busy_q       <= 1'b1;
      owner_conv_q <= grant_conv;
    end
  end

  // Data fans out, only the owner sees valid
  assign wgt_rsp_o  = '{valid: busy_q && !owner_conv_q && mem_rsp_i.valid,
                        data:  mem_rsp_i.data};
  assign conv_rsp_o = '{valid: busy_q && owner_conv_q && mem_rsp_i.valid,
                        data:  mem_rsp_i.data};

  a_rsp_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_rsp_i.valid |-> busy_q);

  a_owner_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_q && !mem_rsp_i.valid |=> busy_q && $stable(owner_conv_q)
      && (!mem_req_o.valid || $stable(mem_req_o.addr)));

endmodule

//--- weight_loader.sv
`timescale 1ns/10ps

module weight_loader
  import aether_pkg::*;
#(
  parameter int DataWidth = 8
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    rst_i,
  input  logic                    start_i,
  input  logic [MemAddrWidth-1:0] base_i,
  output mem_req_t                req_o,
  input  mem_rsp_t                rsp_i,
  output logic                    busy_o,
  output logic [9*DataWidth-1:0]  kernel_o  // Weight k at k*DataWidth
);

  localparam int KernelBits = 9 * DataWidth;
  localparam int WordCount  = (KernelBits + MemDataWidth - 1) / MemDataWidth;
  localparam int BufBits    = WordCount * MemDataWidth;
  localparam int CntWidth   = $clog2(WordCount);

  typedef enum logic [1:0] {IDLE, FETCH, WAIT} state_e;

  state_e                  state_q;
  logic [CntWidth-1:0]     cnt_q;    // Word being fetched
  logic [MemAddrWidth-1:0] base_q;
  logic [BufBits-1:0]      words_q;  // First word ends up lowest

  assign busy_o = (state_q != IDLE);
  assign req_o  = '{valid: state_q == FETCH, addr: base_q + MemAddrWidth'(cnt_q)};

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else if (rst_i)
    begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (start_i)
          begin
            state_q <= FETCH;
            cnt_q   <= '0;
          end
        FETCH:
          if (rsp_i.valid)
          begin
            if (cnt_q == CntWidth'(WordCount - 1))
              state_q <= WAIT;
            else
              cnt_q <= cnt_q + 1'b1;
          end
        WAIT:    state_q <= IDLE;  // Kernel copied out here
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE)
      base_q <= base_i;
    if (state_q == FETCH && rsp_i.valid)
      words_q <= {rsp_i.data, words_q[BufBits-1:MemDataWidth]};
    if (state_q == WAIT)
      kernel_o <= words_q[KernelBits-1:0];  // Spare high byte dropped
  end

endmodule

//--- conv_engine.sv
`timescale 1ns/10ps

module conv_engine
  import aether_pkg::*;
#(
  parameter int DataWidth = 8,
  parameter int MaxWidth  = 32,
  parameter int AccWidth  = 20
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       rst_i,
  input  logic                       start_i,
  input  logic [MemAddrWidth-1:0]    base_i,
  input  logic [15:0]                width_i,
  input  logic [9*DataWidth-1:0]     kernel_i,
  output mem_req_t                   req_o,
  input  mem_rsp_t                   rsp_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic signed [AccWidth-1:0] result_o,
  output logic                       result_valid_o
);

  localparam int IdxWidth  = $clog2(MaxWidth);
  localparam int WidWidth  = $clog2(MaxWidth + 1);
  localparam int PixWidth  = $clog2(MaxWidth * MaxWidth + 1);
  localparam int ProdWidth = 2 * DataWidth;

  typedef enum logic [1:0] {IDLE, FETCH, UNPACK, DRAIN} state_e;

  state_e                  state_q;
  logic [WidWidth-1:0]     width_q;
  logic [PixWidth-1:0]     total_q;     // W*W pixels
  logic [PixWidth-1:0]     pix_q;       // Pixels pushed so far
  logic [PixWidth-1:0]     word_cnt_q;
  logic                    half_q;      // High byte next
  logic [IdxWidth-1:0]     col_q;
  logic [IdxWidth-1:0]     row_q;
  logic [MemAddrWidth-1:0] base_q;
  logic [MemDataWidth-1:0] data_q;
  logic [9*DataWidth-1:0]  kernel_q;    // Frozen for the whole run

  logic                    push;
  logic                    last_pix;
  logic                    col_end;
  logic [DataWidth-1:0]    pixel;

  assign busy_o   = (state_q != IDLE);
  assign push     = (state_q == UNPACK);
  assign pixel    = half_q ? data_q[2*DataWidth-1:DataWidth] : data_q[DataWidth-1:0];
  assign last_pix = (pix_q == total_q - 1'b1);
  assign col_end  = (WidWidth'(col_q) == width_q - 1'b1);
  assign req_o    = '{valid: state_q == FETCH, addr: base_q + MemAddrWidth'(word_cnt_q)};

  // ------------------------------
  // Fetch and unpack control
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= IDLE;
      width_q <= '0;
      total_q <= '0;
      pix_q <= '0;
      word_cnt_q <= '0;
      half_q <= 1'b0;
      col_q <= '0;
      row_q <= '0;
    end
    else if (rst_i)
      state_q <= IDLE;
    else
    begin
      case (state_q)
        IDLE:
          if (start_i)
          begin
            state_q    <= FETCH;
            width_q    <= width_i[WidWidth-1:0];
            total_q    <= PixWidth'(width_i[WidWidth-1:0]) * PixWidth'(width_i[WidWidth-1:0]);
            pix_q      <= '0;
            word_cnt_q <= '0;
            half_q     <= 1'b0;
            col_q      <= '0;
            row_q      <= '0;
          end
        FETCH:
          if (rsp_i.valid)
          begin
            state_q    <= UNPACK;
            word_cnt_q <= word_cnt_q + 1'b1;
          end
        UNPACK:
        begin
          pix_q  <= pix_q + 1'b1;
          half_q <= !half_q;
          col_q  <= col_end ? '0 : col_q + 1'b1;
          if (col_end)
            row_q <= row_q + 1'b1;
          if (last_pix)
            state_q <= DRAIN;  // Odd total leaves the last high byte unused
          else if (half_q)
            state_q <= FETCH;
        end
        DRAIN:   if (done_o) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE)
    begin
      base_q   <= base_i;
      kernel_q <= kernel_i;
    end
    if (state_q == FETCH && rsp_i.valid)
      data_q <= rsp_i.data;
  end

  // ------------------------------
  // Line buffers and window
  // ------------------------------
  logic [DataWidth-1:0] line1_q [MaxWidth];  // Row above
  logic [DataWidth-1:0] line2_q [MaxWidth];  // Two rows above
  logic [DataWidth-1:0] win_q [3][3];        // [row][col], [2][2] newest

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      line1_q[col_q] <= pixel;
      line2_q[col_q] <= line1_q[col_q];
      for (int r = 0; r < 3; r++)
      begin
        win_q[r][0] <= win_q[r][1];
        win_q[r][1] <= win_q[r][2];
      end
      win_q[0][2] <= line2_q[col_q];
      win_q[1][2] <= line1_q[col_q];
      win_q[2][2] <= pixel;
    end
  end

  // ------------------------------
  // Multiply then sum
  // ------------------------------
  logic                        win_vld_q;
  logic                        win_last_q;
  logic                        prod_vld_q;
  logic                        prod_last_q;
  logic signed [ProdWidth-1:0] prod_q [9];
  logic signed [AccWidth-1:0]  sum;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      win_vld_q <= 1'b0;
      win_last_q <= 1'b0;
      prod_vld_q <= 1'b0;
      prod_last_q <= 1'b0;
      result_valid_o <= 1'b0;
      done_o <= 1'b0;
    end
    else if (rst_i)
    begin
      win_vld_q <= 1'b0;
      win_last_q <= 1'b0;
      prod_vld_q <= 1'b0;
      prod_last_q <= 1'b0;
      result_valid_o <= 1'b0;
      done_o <= 1'b0;
    end
    else
    begin
      win_vld_q      <= push && row_q >= IdxWidth'(2) && col_q >= IdxWidth'(2);
      win_last_q     <= push && last_pix;
      prod_vld_q     <= win_vld_q;
      prod_last_q    <= win_last_q;
      result_valid_o <= prod_vld_q;
      done_o         <= prod_last_q;  // Rides with the final result
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int k = 0; k < 9; k++)
    begin
      prod_q[k] <= $signed(win_q[k/3][k%3]) * $signed(kernel_q[k*DataWidth +: DataWidth]);
    end
    if (prod_vld_q)
      result_o <= sum;
  end

  always_comb
  begin
    sum = '0;
    for (int k = 0; k < 9; k++)
    begin
      sum = sum + {{(AccWidth-ProdWidth){prod_q[k][ProdWidth-1]}}, prod_q[k]};
    end
  end

  // Width from the register file must fit the line buffers
  a_width_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i && state_q == IDLE && !rst_i |-> width_i >= 16'd3 && width_i <= 16'(MaxWidth));

endmodule

//--- aether_engine.sv
`timescale 1ns/10ps

module aether_engine
  import aether_pkg::*;
#(
  parameter int DataWidth = 8,
  parameter int MaxWidth  = 32,  // Line buffer depth
  parameter int AccWidth  = 20
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  opcode_e                    instruction_i,
  input  logic [3:0]                 param_1_i,
  input  logic [15:0]                param_2_i,
  output logic [15:0]                data_o,
  output logic                       interrupt_o,
  output logic signed [AccWidth-1:0] result_o,
  output logic                       result_valid_o,
  output mem_req_t                   mem_req_o,
  input  mem_rsp_t                   mem_rsp_i
);

  // Decoder to fetchers
  logic                    wgt_start;
  logic                    conv_start;
  logic [MemAddrWidth-1:0] wgt_base;
  logic [MemAddrWidth-1:0] act_base;
  logic [15:0]             width;
  logic                    rst_conv;
  logic                    rst_cwgt;

  // Fetchers back to decoder
  logic wgt_busy;
  logic conv_busy;
  logic conv_done;

  logic [9*DataWidth-1:0] kernel;

  // Fetcher side of the arbiter
  mem_req_t wgt_req;
  mem_rsp_t wgt_rsp;
  mem_req_t conv_req;
  mem_rsp_t conv_rsp;

  aether_decoder decode_inst (
    .clk_i,
    .arst_n_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .wgt_busy_i   (wgt_busy),
    .conv_busy_i  (conv_busy),
    .conv_done_i  (conv_done),
    .data_o,
    .wgt_start_o  (wgt_start),
    .conv_start_o (conv_start),
    .wgt_base_o   (wgt_base),
    .act_base_o   (act_base),
    .width_o      (width),
    .rst_conv_o   (rst_conv),
    .rst_cwgt_o   (rst_cwgt),
    .interrupt_o
  );

  weight_loader #(
    .DataWidth(DataWidth)
  ) wgt_inst (
    .clk_i,
    .arst_n_i,
    .rst_i    (rst_cwgt),
    .start_i  (wgt_start),
    .base_i   (wgt_base),
    .req_o    (wgt_req),
    .rsp_i    (wgt_rsp),
    .busy_o   (wgt_busy),
    .kernel_o (kernel)
  );

  conv_engine #(
    .DataWidth(DataWidth),
    .MaxWidth (MaxWidth),
    .AccWidth (AccWidth)
  ) conv_inst (
    .clk_i,
    .arst_n_i,
    .rst_i    (rst_conv),
    .start_i  (conv_start),
    .base_i   (act_base),
    .width_i  (width),
    .kernel_i (kernel),
    .req_o    (conv_req),
    .rsp_i    (conv_rsp),
    .busy_o   (conv_busy),
    .done_o   (conv_done),
    .result_o,
    .result_valid_o
  );

  mem_arbiter arb_inst (
    .clk_i,
    .arst_n_i,
    .wgt_req_i  (wgt_req),
    .wgt_rsp_o  (wgt_rsp),
    .conv_req_i (conv_req),
    .conv_rsp_o (conv_rsp),
    .mem_req_o,
    .mem_rsp_i
  );

endmodule

//--- tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model
  import aether_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_req_t req_i,
  input  logic [1:0] latency_i,  // Extra wait cycles, 0 to 3
  output mem_rsp_t rsp_o
);

  logic [MemDataWidth-1:0] mem [0:4095];  // Filled from the testbench top

  logic        busy_q;
  logic [1:0]  cnt_q;
  logic [11:0] addr_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      addr_q <= '0;
      rsp_o  <= '0;
    end
    else
    begin
      rsp_o.valid <= 1'b0;
      if (busy_q)
      begin
        if (cnt_q == 2'd0)
        begin
          rsp_o  <= '{valid: 1'b1, data: mem[addr_q]};
          busy_q <= 1'b0;
        end
        else
          cnt_q <= cnt_q - 1'b1;
      end
      else if (req_i.valid && !rsp_o.valid)  // Old request still held while data is out
      begin
        busy_q <= 1'b1;
        cnt_q  <= latency_i;
        addr_q <= req_i.addr[11:0];
      end
    end
  end

endmodule

//--- tb_aether_engine.sv
`timescale 1ns/10ps

module tb_aether_engine
  import aether_pkg::*;
;

  localparam int AccWidth       = 20;
  localparam int TotalWords     = 5 * 5 + 5 + 8 + 25 + 13;  // Five kernels, four matrices
  localparam int WatchdogCycles = TotalWords * 6 + 2000;

  logic        clk;
  logic        arst_n;
  opcode_e     instruction;
  logic [3:0]  param_1;
  logic [15:0] param_2;
  logic [15:0] data_o;
  logic        interrupt_o;
  logic        result_valid_o;
  logic [1:0]  latency;
  logic signed [AccWidth-1:0] result_o;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;

  logic [31:0] lfsr_q;
  logic [15:0] rd_exp;
  logic signed [AccWidth-1:0] exp_arr [0:63];
  int          exp_cnt;
  int          res_cnt;
  int          irq_cnt;
  int          errors;
  int          total_results;
  string       test_name;

  aether_engine #(.AccWidth(AccWidth)) DUT (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .instruction_i  (instruction),
    .param_1_i      (param_1),
    .param_2_i      (param_2),
    .data_o         (data_o),
    .interrupt_o    (interrupt_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp)
  );

  tb_mem_model mem_inst (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .req_i     (mem_req),
    .latency_i (latency),
    .rsp_o     (mem_rsp)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Signed byte idx of a packed stream starting at word base
  function automatic int mem_byte(input int base, input int idx);
    logic [15:0] word;
    word = mem_inst.mem[(base + idx / 2) & 12'hfff];
    return (idx % 2) ? int'($signed(word[15:8])) : int'($signed(word[7:0]));
  endfunction

  // Reference sums in raster order
  task automatic build_expected(input int kbase, input int abase, input int w);
    int acc;
    exp_cnt = 0;
    for (int i = 0; i < w - 2; i++)
      for (int j = 0; j < w - 2; j++)
      begin
        acc = 0;
        for (int r = 0; r < 3; r++)
          for (int c = 0; c < 3; c++)
            acc += mem_byte(kbase, r * 3 + c) * mem_byte(abase, (i + r) * w + j + c);
        exp_arr[exp_cnt] = acc[AccWidth-1:0];
        exp_cnt++;
      end
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  a_rd_value: assert property (@(posedge clk) disable iff (!arst_n)
    instruction == RDR |=> data_o == rd_exp)
    else
    begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", test_name, rd_exp, data_o);
    end

  a_result: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid_o |-> res_cnt <= exp_cnt && result_o == exp_arr[res_cnt-1])
    else
    begin
      errors++;
      $display("Mismatch %s: expected %0d, actual %0d (result %0d)",
               test_name, exp_arr[res_cnt-1], result_o, res_cnt - 1);
    end

  a_irq_after_last: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid_o && res_cnt == exp_cnt |=> interrupt_o)
    else
    begin
      errors++;
      $display("%s: interrupt did not follow the last result", test_name);
    end

  a_irq_only_at_end: assert property (@(posedge clk) disable iff (!arst_n)
    interrupt_o |-> res_cnt == exp_cnt)
    else
    begin
      errors++;
      $display("%s: interrupt came before all results", test_name);
    end

  a_rsp_with_req: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rsp.valid |-> mem_req.valid)
    else
    begin
      errors++;
      $display("%s: memory response without a pending request", test_name);
    end

  // Counters move on the falling edge, away from the checks
  always @(negedge clk)
  begin
    if (result_valid_o)
    begin
      res_cnt++;
      total_results++;
    end
    if (interrupt_o)
      irq_cnt++;
  end

  always @(posedge clk)
  begin
    #2;
    latency = rand_bits(2);
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic send(input opcode_e op, input logic [3:0] p1, input logic [15:0] p2);
    instruction = op;
    param_1     = p1;
    param_2     = p2;
    @(posedge clk);
    #2;
    instruction = NOP;
    param_1     = '0;
    param_2     = '0;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic rd(input reg_idx_e idx, input logic [15:0] exp);
    rd_exp = exp;
    send(RDR, 4'(idx), 16'h0);
    idle_cycle();
  endtask

  task automatic wait_weights();
    while (DUT.wgt_busy)
      @(negedge clk);
    idle_cycle();
  endtask

  task automatic check_run_end();
    wait (irq_cnt != 0);
    idle_cycle();
    repeat (3) idle_cycle();  // A second pulse would show up here
    assert (res_cnt == exp_cnt && irq_cnt == 1)
    else
    begin
      errors++;
      $display("Mismatch %s: expected %0d results and 1 interrupt, actual %0d and %0d",
               test_name, exp_cnt, res_cnt, irq_cnt);
    end
  endtask

  task automatic run_conv(input string name, input int kbase, input int abase, input int w);
    test_name = name;
    send(WRR, 4'(MSTRT), 16'(kbase));
    send(WRR, 4'(MENDD), 16'(abase));
    send(WRR, 4'(BCFG1), 16'(w));
    send(RST, 4'(CONV), 16'h0);
    rd(STATS, 16'h0000);
    send(LDW, 4'h0, 16'h0);
    idle_cycle();
    rd(STATS, 16'h0001);  // Loader busy
    wait_weights();
    rd(STATS, 16'h0000);
    build_expected(kbase, abase, w);
    res_cnt = 0;
    irq_cnt = 0;
    send(CNV, 4'h0, 16'h0);
    idle_cycle();
    rd(STATS, 16'h0002);  // Engine busy
    check_run_end();
    rd(STATS, 16'h0004);
    send(RST, 4'(CONV), 16'h0);
    rd(STATS, 16'h0000);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    clk           = 1'b0;
    arst_n        = 1'b0;
    instruction   = NOP;
    param_1       = '0;
    param_2       = '0;
    latency       = '0;
    rd_exp        = '0;
    exp_cnt       = 0;
    res_cnt       = 0;
    irq_cnt       = 0;
    errors        = 0;
    total_results = 0;
    test_name     = "reset";
    lfsr_q        = 32'h10f2d7a3;
    for (int a = 0; a < 4096; a++)
      mem_inst.mem[a] = rand_bits(16);

    repeat (2) @(posedge clk);
    #2;
    arst_n = 1'b1;
    idle_cycle();

    test_name = "reset_read";
    rd(VERSN, 16'h6C00);
    rd(HWRID, 16'hB2E9);
    rd(MEMUP, 16'h0000);
    rd(MSTRT, 16'h0000);
    rd(MENDD, 16'h0000);
    rd(BCFG1, 16'h0001);
    rd(STATS, 16'h0000);

    test_name = "write_read";
    send(WRR, 4'(MEMUP), 16'h00A5);
    rd(MEMUP, 16'h00A5);
    send(WRR, 4'(MEMUP), 16'h0000);
    rd(MEMUP, 16'h0000);
    send(WRR, 4'(MSTRT), 16'h1234);
    rd(MSTRT, 16'h1234);
    send(WRR, 4'(MENDD), 16'hBEEF);
    rd(MENDD, 16'hBEEF);
    send(WRR, 4'(BCFG1), 16'h0007);
    rd(BCFG1, 16'h0007);
    send(WRR, 4'(VERSN), 16'h1111);
    rd(VERSN, 16'h6C00);
    send(WRR, 4'(HWRID), 16'h2222);
    rd(HWRID, 16'hB2E9);

    run_conv("conv_w3", 16'h0010, 16'h0100, 3);
    run_conv("conv_w4", 16'h0020, 16'h0200, 4);
    run_conv("conv_w7", 16'h0030, 16'h0300, 7);

    // Fresh kernel first, then a second load racing the engine
    test_name = "conv_shared";
    send(WRR, 4'(MSTRT), 16'h0040);
    send(WRR, 4'(MENDD), 16'h0400);
    send(WRR, 4'(BCFG1), 16'h0005);
    send(LDW, 4'h0, 16'h0);
    idle_cycle();
    wait_weights();
    build_expected(16'h0040, 16'h0400, 5);
    send(WRR, 4'(MSTRT), 16'h0050);
    res_cnt = 0;
    irq_cnt = 0;
    send(LDW, 4'h0, 16'h0);
    send(CNV, 4'h0, 16'h0);
    idle_cycle();
    rd(STATS, 16'h0003);  // Both fetchers on the port
    check_run_end();
    wait_weights();
    rd(STATS, 16'h0004);
    send(RST, 4'(CONV), 16'h0);
    rd(STATS, 16'h0000);

    $display("Run complete: %0d errors, %0d results checked", errors, total_results);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired in %s after %0d cycles", test_name, WatchdogCycles);
    $display("Run aborted: %0d errors, %0d results checked", errors, total_results);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- flist.f
aether_pkg.sv
aether_decoder.sv
mem_arbiter.sv
weight_loader.sv
conv_engine.sv
aether_engine.sv
tb_mem_model.sv
tb_aether_engine.sv

//--- Makefile
# Verilator flow for the convolution accelerator

VERILATOR ?= verilator
TOP       ?= tb_aether_engine
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		-f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(PASS_MSG)" $(LOG); then \
		exit 0; \
	else \
		echo "Simulation failed, exit code $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
